//--- files.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/wr_ctrl_pkg.sv
rtl/wr_cmd_reg.sv
rtl/wr_data_fifo.sv
rtl/wr_data_channel.sv
rtl/wr_addr_channel.sv
rtl/wr_resp_tracker.sv
rtl/axi_write_master.sv
verification/wr_checker.sv
verification/tb_axi_write_master.sv

//--- rtl/axi_pkg.sv
// AXI bus field types shared by the write master blocks
`include "axi_wr_params.svh"

package axi_pkg;

  // Byte address, one bus word
  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

  // One data beat
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;

  // Byte enables, one per data byte
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;

  // AxLEN field, beats minus one
  typedef logic [7:0] axi_len_t;

endpackage

//--- rtl/axi_wr_params.svh
// AXI write master parameters: bus widths, burst limits, FIFO depth, outstanding limit
`ifndef AXI_WR_PARAMS_SVH
`define AXI_WR_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
// Width of the host byte count
`define XFER_SIZE_W 20

////////////////////////////////////////////////////////////
// Protocol and buffering limits
////////////////////////////////////////////////////////////
`define MAX_BURST_BEATS 256
`define MAX_BURST_BYTES 4096
// Bursts allowed to wait for a B response
`define MAX_OUTSTANDING 8
// Stream buffer entries, power of two
`define WR_FIFO_DEPTH 32

`endif

//--- rtl/axi_write_master.sv
// AXI4 write master top: moves a stream into memory in incrementing bursts
module axi_write_master (
  input  logic                    aclk,
  input  logic                    areset,
  // Host control
  input  logic                    ctrl_start,
  input  axi_pkg::axi_addr_t      ctrl_addr_offset,
  input  wr_ctrl_pkg::xfer_size_t ctrl_xfer_size,
  output logic                    ctrl_done,
  // AW channel
  output logic                    awvalid,
  input  logic                    awready,
  output axi_pkg::axi_addr_t      awaddr,
  output axi_pkg::axi_len_t       awlen,
  // W channel
  output logic                    wvalid,
  input  logic                    wready,
  output axi_pkg::axi_data_t      wdata,
  output axi_pkg::axi_strb_t      wstrb,
  output logic                    wlast,
  // B channel
  input  logic                    bvalid,
  output logic                    bready,
  // Stream input
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  axi_pkg::axi_data_t      s_axis_tdata
);

  // Command fan-out
  logic                  start;
  axi_pkg::axi_addr_t    start_addr;
  wr_ctrl_pkg::txn_cnt_t total_bursts;
  axi_pkg::axi_len_t     final_len;
  axi_pkg::axi_strb_t    final_strb;
  // FIFO side
  logic                  fifo_full;
  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  fifo_valid;
  axi_pkg::axi_data_t    fifo_data;
  // Channel handshakes
  logic                  first_beat;
  logic                  aw_fire;
  logic                  aw_stall;

  // Stream is stalled only by a full FIFO
  assign s_axis_tready = ~fifo_full;
  assign fifo_push     = s_axis_tvalid & s_axis_tready;

  wr_cmd_reg u_cmd_reg (
    .aclk(aclk), .areset(areset), .ctrl_start(ctrl_start),
    .ctrl_addr_offset(ctrl_addr_offset), .ctrl_xfer_size(ctrl_xfer_size),
    .start(start), .start_addr(start_addr), .total_bursts(total_bursts),
    .final_len(final_len), .final_strb(final_strb)
  );

  wr_data_fifo u_data_fifo (
    .aclk(aclk), .areset(areset), .push(fifo_push), .push_data(s_axis_tdata),
    .pop(fifo_pop), .full(fifo_full), .valid(fifo_valid), .data(fifo_data)
  );

  wr_data_channel u_data_channel (
    .aclk(aclk), .areset(areset), .start(start), .total_bursts(total_bursts),
    .final_len(final_len), .final_strb(final_strb), .fifo_valid(fifo_valid),
    .fifo_data(fifo_data), .wready(wready), .fifo_pop(fifo_pop), .wvalid(wvalid),
    .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .first_beat(first_beat)
  );

  wr_addr_channel u_addr_channel (
    .aclk(aclk), .areset(areset), .start(start), .start_addr(start_addr),
    .total_bursts(total_bursts), .final_len(final_len), .first_beat(first_beat),
    .aw_stall(aw_stall), .awready(awready), .awvalid(awvalid), .awaddr(awaddr),
    .awlen(awlen), .aw_fire(aw_fire)
  );

  wr_resp_tracker u_resp_tracker (
    .aclk(aclk), .areset(areset), .start(start), .total_bursts(total_bursts),
    .aw_fire(aw_fire), .bvalid(bvalid), .bready(bready), .aw_stall(aw_stall),
    .ctrl_done(ctrl_done)
  );

endmodule

//--- rtl/wr_addr_channel.sv
// AW channel: one burst request per first beat, paced by the outstanding limit
`include "axi_wr_params.svh"

module wr_addr_channel (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  axi_pkg::axi_addr_t    start_addr,
  input  wr_ctrl_pkg::txn_cnt_t total_bursts,
  input  axi_pkg::axi_len_t     final_len,
  input  logic                  first_beat,
  input  logic                  aw_stall,
  input  logic                  awready,
  output logic                  awvalid,
  output axi_pkg::axi_addr_t    awaddr,
  output axi_pkg::axi_len_t     awlen,
  output logic                  aw_fire
);

  localparam int BEAT_BYTES = `AXI_DATA_W / 8;
  // Full burst, bounded by both protocol limits
  localparam int BURST_BYTES =
    (`MAX_BURST_BEATS * BEAT_BYTES < `MAX_BURST_BYTES) ?
    `MAX_BURST_BEATS * BEAT_BYTES : `MAX_BURST_BYTES;
  localparam axi_pkg::axi_len_t FULL_LEN = axi_pkg::axi_len_t'(BURST_BYTES / BEAT_BYTES - 1);

  // First beats seen on W, not yet matched by an AW
  logic [$bits(wr_ctrl_pkg::txn_cnt_t):0] pending;
  wr_ctrl_pkg::txn_cnt_t                  aw_left;
  logic                                   have_beat;

  assign aw_fire   = awvalid & awready;
  assign have_beat = first_beat || (pending != '0);
  assign awlen     = (aw_left == '0) ? final_len : FULL_LEN;

  ////////////////////////////////////////////////////////////
  // Request pacing
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      pending <= '0;
    end else begin
      case ({first_beat, aw_fire})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  // Held until accepted, then low for a cycle before the next one
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (!awvalid) begin
      awvalid <= have_beat && !aw_stall;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and burst bookkeeping
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start) begin
      awaddr <= start_addr;
    end else if (aw_fire) begin
      awaddr <= awaddr + axi_pkg::axi_addr_t'(BURST_BYTES);
    end
  end

  // Zero marks the last burst, which takes the short length
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_left <= '0;
    end else if (start) begin
      aw_left <= total_bursts;
    end else if (aw_fire && (aw_left != '0)) begin
      aw_left <= aw_left - 1'b1;
    end
  end

  // Request must not change under back-pressure
  a_aw_hold: assert property (
    @(posedge aclk) disable iff (areset)
    (awvalid && !awready) |=> awvalid && $stable(awaddr) && $stable(awlen)
  ) else $error("wr_addr_channel: AW request changed before awready");

endmodule

//--- rtl/wr_cmd_reg.sv
// Command register: captures a write command and derives its burst plan
`include "axi_wr_params.svh"

module wr_cmd_reg (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    ctrl_start,
  input  axi_pkg::axi_addr_t      ctrl_addr_offset,
  input  wr_ctrl_pkg::xfer_size_t ctrl_xfer_size,
  output logic                    start,
  output axi_pkg::axi_addr_t      start_addr,
  output wr_ctrl_pkg::txn_cnt_t   total_bursts,
  output axi_pkg::axi_len_t       final_len,
  output axi_pkg::axi_strb_t      final_strb
);

  // Address bits below one bus word
  localparam int LANE_BITS = $clog2(`AXI_DATA_W / 8);

  logic                   start_d1;
  wr_ctrl_pkg::beat_cnt_t total_beats;
  logic [LANE_BITS-1:0]   byte_rem;
  axi_pkg::axi_strb_t     rem_strb;

  // Two-stage start, derived values settle in between
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 1: sample the command
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      start_addr <= ctrl_addr_offset;
      byte_rem   <= ctrl_xfer_size[LANE_BITS-1:0];
      // Round up to whole beats, kept as beats minus one
      if (ctrl_xfer_size[LANE_BITS-1:0] != '0) begin
        total_beats <= ctrl_xfer_size[`XFER_SIZE_W-1:LANE_BITS];
      end else begin
        total_beats <= ctrl_xfer_size[`XFER_SIZE_W-1:LANE_BITS] - 1'b1;
      end
    end
  end

  // Partial last word keeps only the low bytes
  always_comb begin
    rem_strb = '1;
    if (byte_rem != '0) begin
      for (int i = 0; i < $bits(axi_pkg::axi_strb_t); i++) begin
        rem_strb[i] = (LANE_BITS'(i) < byte_rem);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: split beats into bursts
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      // Upper bits count full bursts, low byte is the last burst length
      total_bursts <= total_beats[$bits(wr_ctrl_pkg::beat_cnt_t)-1:$bits(axi_pkg::axi_len_t)];
      final_len    <= total_beats[$bits(axi_pkg::axi_len_t)-1:0];
      final_strb   <= rem_strb;
    end
  end

endmodule

//--- rtl/wr_ctrl_pkg.sv
// Transfer control types: counter widths and the W channel run phase
`include "axi_wr_params.svh"

package wr_ctrl_pkg;

  // Host byte count
  typedef logic [`XFER_SIZE_W-1:0] xfer_size_t;

  // Total beats of a command minus one
  typedef logic [`XFER_SIZE_W-$clog2(`AXI_DATA_W/8)-1:0] beat_cnt_t;

  // Beat index inside one burst
  typedef logic [$clog2(`MAX_BURST_BEATS)-1:0] burst_beat_t;

  // Bursts still to go, minus one
  typedef logic [$bits(beat_cnt_t)-$clog2(`MAX_BURST_BEATS)-1:0] txn_cnt_t;

  // Free outstanding-burst slots, 0 up to the limit
  typedef logic [$clog2(`MAX_OUTSTANDING+1)-1:0] vacancy_t;

  // W channel run phase
  typedef enum logic {W_IDLE, W_RUN} w_phase_e;

endpackage

//--- rtl/wr_data_channel.sv
// W channel that gates beats by run phase and makes wlast, the final strobe and first-beat pulses
module wr_data_channel (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  wr_ctrl_pkg::txn_cnt_t total_bursts,
  input  axi_pkg::axi_len_t     final_len,
  input  axi_pkg::axi_strb_t    final_strb,
  input  logic                  fifo_valid,
  input  axi_pkg::axi_data_t    fifo_data,
  input  logic                  wready,
  output logic                  fifo_pop,
  output logic                  wvalid,
  output axi_pkg::axi_data_t    wdata,
  output axi_pkg::axi_strb_t    wstrb,
  output logic                  wlast,
  output logic                  first_beat
);

  wr_ctrl_pkg::w_phase_e    phase;
  wr_ctrl_pkg::burst_beat_t beats_left;
  wr_ctrl_pkg::txn_cnt_t    bursts_left;
  logic                     last_burst;
  logic                     w_fire;
  logic                     first_seen;

  // No beat leaves before the command sizes are known
  assign wvalid   = fifo_valid && (phase == wr_ctrl_pkg::W_RUN);
  assign w_fire   = wvalid & wready;
  assign fifo_pop = w_fire;
  assign wdata    = fifo_data;

  assign wlast      = (beats_left == '0);
  assign last_burst = (bursts_left == '0);
  // Strobe clipping applies only to the very last beat
  assign wstrb      = (wlast && last_burst) ? final_strb : '1;

  ////////////////////////////////////////////////////////////
  // Run phase
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      phase <= wr_ctrl_pkg::W_IDLE;
    end else if (start) begin
      phase <= wr_ctrl_pkg::W_RUN;
    end else if (w_fire && wlast && last_burst) begin
      phase <= wr_ctrl_pkg::W_IDLE;
    end
  end

  ////////////////////////////////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left  <= '1;
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= total_bursts;
      // Single-burst command starts on the short length
      beats_left  <= (total_bursts == '0) ? final_len : '1;
    end else if (w_fire) begin
      if (wlast) begin
        bursts_left <= bursts_left - 1'b1;
        // Reload with the short length when the next burst is the last
        beats_left  <= (bursts_left == wr_ctrl_pkg::txn_cnt_t'(1)) ? final_len : '1;
      end else begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  // One pulse per burst a cycle after its first beat shows on W
  always_ff @(posedge aclk) begin
    if (areset) begin
      first_seen <= 1'b0;
      first_beat <= 1'b0;
    end else begin
      first_beat <= wvalid && !first_seen;
      if (w_fire && wlast) begin
        first_seen <= 1'b0;
      end else if (wvalid) begin
        first_seen <= 1'b1;
      end
    end
  end

  // A stalled beat keeps its data, last flag and strobe until wready
  a_w_hold: assert property (
    @(posedge aclk) disable iff (areset)
    (wvalid && !wready) |=> wvalid && $stable(wdata) && $stable(wlast) && $stable(wstrb)
  ) else $error("wr_data_channel: W beat changed before wready");

endmodule

//--- rtl/wr_data_fifo.sv
// First-word-fall-through FIFO between the stream port and the W channel
`include "axi_wr_params.svh"

module wr_data_fifo (
  input  logic               aclk,
  input  logic               areset,
  input  logic               push,
  input  axi_pkg::axi_data_t push_data,
  input  logic               pop,
  output logic               full,
  output logic               valid,
  output axi_pkg::axi_data_t data
);

  localparam int DEPTH = `WR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  axi_pkg::axi_data_t mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  // One extra bit so that a full FIFO is visible
  logic [PTR_W:0]     count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & valid;

  // Head word is shown while anything is stored
  assign valid = (count != '0);
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign data  = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Upstream must respect the full flag, a dropped word is lost data
  a_no_push_full: assert property (
    @(posedge aclk) disable iff (areset) push |-> !full
  ) else $error("wr_data_fifo: push while full");

endmodule

//--- rtl/wr_resp_tracker.sv
// B channel: outstanding-burst vacancy, response count and the done strobe
`include "axi_wr_params.svh"

module wr_resp_tracker (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  wr_ctrl_pkg::txn_cnt_t total_bursts,
  input  logic                  aw_fire,
  input  logic                  bvalid,
  output logic                  bready,
  output logic                  aw_stall,
  output logic                  ctrl_done
);

  localparam wr_ctrl_pkg::vacancy_t VAC_MAX = wr_ctrl_pkg::vacancy_t'(`MAX_OUTSTANDING);

  wr_ctrl_pkg::vacancy_t vacancy;
  wr_ctrl_pkg::txn_cnt_t b_left;
  logic                  busy;
  logic                  b_fire;

  // Responses are always accepted
  assign bready   = 1'b1;
  assign b_fire   = bvalid & bready;
  assign aw_stall = (vacancy == '0);

  ////////////////////////////////////////////////////////////
  // Outstanding slots
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= VAC_MAX;
    end else begin
      case ({aw_fire, b_fire})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  // Counts down responses, done one cycle after the last one
  always_ff @(posedge aclk) begin
    if (areset) begin
      b_left    <= '0;
      busy      <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= b_fire && busy && (b_left == '0);
      if (start) begin
        busy   <= 1'b1;
        b_left <= total_bursts;
      end else if (b_fire && busy) begin
        if (b_left == '0) begin
          busy <= 1'b0;
        end else begin
          b_left <= b_left - 1'b1;
        end
      end
    end
  end

  // A response needs an accepted AW request behind it
  a_no_stray_b: assert property (
    @(posedge aclk) disable iff (areset) b_fire |-> (vacancy != VAC_MAX)
  ) else $error("wr_resp_tracker: B response with no burst outstanding");

endmodule

//--- run.sh
#!/bin/sh
# Builds the AXI write master testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --timescale 1ns/1ps -f files.f \
  --top-module tb_axi_write_master -o tb_sim > build.log 2>&1 ||
  { echo "Build error, see build.log"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAIL"; exit 1; }
grep -q "Testbench passed" sim.log && echo "Simulation PASS" ||
  { echo "Simulation FAIL, no result in sim.log"; exit 1; }

//--- verification/tb_axi_write_master.sv
// Testbench for the AXI write master: random commands, stream source and AXI slave
module tb_axi_write_master;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_CMDS     = 20;
  localparam int          MAX_SIZE     = 3000;
  localparam int          STREAM_LIMIT = 2000;
  localparam int          DONE_LIMIT   = 20000;
  localparam logic [31:0] SEED         = 32'h90ace849;

  logic                    aclk;
  logic                    areset;
  logic                    ctrl_start;
  axi_pkg::axi_addr_t      ctrl_addr_offset;
  wr_ctrl_pkg::xfer_size_t ctrl_xfer_size;
  logic                    ctrl_done;
  logic                    awvalid;
  logic                    awready = 1'b0;
  axi_pkg::axi_addr_t      awaddr;
  axi_pkg::axi_len_t       awlen;
  logic                    wvalid;
  logic                    wready = 1'b0;
  axi_pkg::axi_data_t      wdata;
  axi_pkg::axi_strb_t      wstrb;
  logic                    wlast;
  logic                    bvalid = 1'b0;
  logic                    bready;
  logic                    s_axis_tvalid;
  logic                    s_axis_tready;
  axi_pkg::axi_data_t      s_axis_tdata;
  logic                    test_end;

  // Separate streams for host side and slave side
  logic [31:0] stim_rng;
  logic [31:0] slave_rng = ~SEED;
  bit          timed_out;
  int          check_errors;
  int          check_total;
  int          cmd_seen;

  // Slave bookkeeping, due cycle per queued response
  int unsigned resp_due [$];
  int unsigned slave_cycle;
  int          aw_accepted;
  int          b_issued;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  axi_write_master u_dut (
    .aclk(aclk), .areset(areset), .ctrl_start(ctrl_start),
    .ctrl_addr_offset(ctrl_addr_offset), .ctrl_xfer_size(ctrl_xfer_size),
    .ctrl_done(ctrl_done), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .awlen(awlen), .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .wlast(wlast), .bvalid(bvalid), .bready(bready), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .s_axis_tdata(s_axis_tdata)
  );

  wr_checker u_checker (
    .aclk(aclk), .areset(areset), .ctrl_start(ctrl_start),
    .ctrl_addr_offset(ctrl_addr_offset), .ctrl_xfer_size(ctrl_xfer_size),
    .ctrl_done(ctrl_done), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .awlen(awlen), .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .wlast(wlast), .bvalid(bvalid), .bready(bready), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .s_axis_tdata(s_axis_tdata), .test_end(test_end),
    .error_count(check_errors), .check_count(check_total), .cmd_count(cmd_seen)
  );

  ////////////////////////////////////////////////////////////
  // AXI slave responder
  ////////////////////////////////////////////////////////////
  // Valid signals are stable between rising edges, so handshakes are known here
  always @(negedge aclk) begin
    if (areset) begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
    end else begin
      slave_cycle++;
      slave_rng = xorshift32(slave_rng);
      // Response only once its burst has both AW and last W behind it
      if (resp_due.size() != 0 && resp_due[0] <= slave_cycle &&
          aw_accepted > b_issued && bready) begin
        bvalid = 1'b1;
        void'(resp_due.pop_front());
        b_issued++;
      end else begin
        bvalid = 1'b0;
      end
      awready = slave_rng[0] | slave_rng[1];
      wready  = slave_rng[2] | slave_rng[3];
      if (awvalid && awready) aw_accepted++;
      if (wvalid && wready && wlast) begin
        resp_due.push_back(slave_cycle + 1 + slave_rng[6:4]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Host and stream stimulus
  ////////////////////////////////////////////////////////////
  // Feeds the given number of beats with random gaps
  task automatic stream_beats(input int beats);
    int sent;
    int stall;
    sent  = 0;
    stall = 0;
    while (sent < beats && !timed_out) begin
      stim_rng = xorshift32(stim_rng);
      s_axis_tvalid = (stim_rng[1:0] != 2'b00);
      stim_rng = xorshift32(stim_rng);
      s_axis_tdata = stim_rng;
      if (s_axis_tvalid && s_axis_tready) begin
        sent++;
        stall = 0;
      end else begin
        stall++;
        if (stall > STREAM_LIMIT) begin
          $display("Timeout: stream port accepted nothing for %0d cycles", stall);
          timed_out = 1'b1;
        end
      end
      @(negedge aclk);
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic wait_for_done(input int idx);
    int cycles;
    cycles = 0;
    while (!ctrl_done && cycles < DONE_LIMIT) begin
      @(negedge aclk);
      cycles++;
    end
    if (!ctrl_done) begin
      $display("Timeout: no ctrl_done for command %0d after %0d cycles", idx, cycles);
      timed_out = 1'b1;
    end
  endtask

  // Random 1 KB aligned offset, size from 1 to MAX_SIZE bytes
  task automatic run_command(input int idx);
    int size;
    stim_rng = xorshift32(stim_rng);
    ctrl_addr_offset = {stim_rng[31:10], 10'b0};
    stim_rng = xorshift32(stim_rng);
    size = int'(stim_rng % MAX_SIZE) + 1;
    ctrl_xfer_size = wr_ctrl_pkg::xfer_size_t'(size);
    ctrl_start = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    stream_beats((size + 3) / 4);
    if (!timed_out) wait_for_done(idx);
    stim_rng = xorshift32(stim_rng);
    repeat (1 + stim_rng[2:0]) @(negedge aclk);
  endtask

  initial begin
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    s_axis_tvalid    = 1'b0;
    s_axis_tdata     = '0;
    test_end         = 1'b0;
    timed_out        = 1'b0;
    stim_rng         = SEED;
    repeat (10) @(negedge aclk);
    areset = 1'b0;
    repeat (4) @(negedge aclk);
    for (int n = 0; n < NUM_CMDS; n++) begin
      if (!timed_out) run_command(n);
    end
    // Closing checks in the checker
    test_end = 1'b1;
    @(negedge aclk);
    test_end = 1'b0;
    @(negedge aclk);
    $display("Commands %0d, checks %0d, errors %0d, timeouts %0d",
             cmd_seen, check_total, check_errors, timed_out);
    if (timed_out || check_errors != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

//--- verification/wr_checker.sv
// Scoreboard that models each write command and compares the AXI write master ports
`include "axi_wr_params.svh"

module wr_checker (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    ctrl_start,
  input  axi_pkg::axi_addr_t      ctrl_addr_offset,
  input  wr_ctrl_pkg::xfer_size_t ctrl_xfer_size,
  input  logic                    ctrl_done,
  input  logic                    awvalid,
  input  logic                    awready,
  input  axi_pkg::axi_addr_t      awaddr,
  input  axi_pkg::axi_len_t       awlen,
  input  logic                    wvalid,
  input  logic                    wready,
  input  axi_pkg::axi_data_t      wdata,
  input  axi_pkg::axi_strb_t      wstrb,
  input  logic                    wlast,
  input  logic                    bvalid,
  input  logic                    bready,
  input  logic                    s_axis_tvalid,
  input  logic                    s_axis_tready,
  input  axi_pkg::axi_data_t      s_axis_tdata,
  input  logic                    test_end,
  output int                      error_count,
  output int                      check_count,
  output int                      cmd_count
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BEAT_BYTES  = `AXI_DATA_W / 8;
  localparam int BURST_BYTES = `MAX_BURST_BEATS * BEAT_BYTES;

  // Expected AW requests of the running command
  axi_pkg::axi_addr_t exp_addr_q [$];
  axi_pkg::axi_len_t  exp_len_q [$];
  // Stream beats accepted and not yet seen on W
  axi_pkg::axi_data_t data_q [$];

  int cur_size;
  int cur_beats;
  int cur_bursts;
  int w_idx;
  int b_in_cmd;
  int aw_total;
  int b_total;
  int w_bursts_seen;
  int done_count;
  bit cmd_active;
  bit w_open;
  bit done_due;
  bit final_b;

  ////////////////////////////////////////////////////////////
  // Reporting helpers
  ////////////////////////////////////////////////////////////
  task automatic value_error(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    error_count++;
    $display("ERROR %0t ns: %s is 'h%h, expected 'h%h", $time, what, got, exp);
  endtask

  task automatic protocol_error(input string msg);
    error_count++;
    $display("Problem at %0t ns: %s", $time, msg);
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      value_error(what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Command model
  ////////////////////////////////////////////////////////////
  // One AW per 256 beats with the address stepping by a full burst
  task automatic load_command(input axi_pkg::axi_addr_t addr, input int size);
    if (cmd_active) begin
      protocol_error("ctrl_start while a transfer is still active");
    end
    cmd_count++;
    cur_size   = size;
    cur_beats  = (size + BEAT_BYTES - 1) / BEAT_BYTES;
    cur_bursts = (cur_beats + `MAX_BURST_BEATS - 1) / `MAX_BURST_BEATS;
    w_idx      = 0;
    b_in_cmd   = 0;
    cmd_active = 1'b1;
    for (int k = 0; k < cur_bursts; k++) begin
      exp_addr_q.push_back(addr + axi_pkg::axi_addr_t'(k * BURST_BYTES));
      if (k == cur_bursts - 1) begin
        exp_len_q.push_back(axi_pkg::axi_len_t'((cur_beats - 1) % `MAX_BURST_BEATS));
      end else begin
        exp_len_q.push_back(axi_pkg::axi_len_t'(`MAX_BURST_BEATS - 1));
      end
    end
  endtask

  // Data, wlast and strobe of one accepted W beat
  task automatic check_w_beat();
    axi_pkg::axi_strb_t exp_strb;
    logic               exp_last;
    if (!cmd_active || w_idx >= cur_beats) begin
      protocol_error("W beat outside the beats of a command");
    end else if (data_q.size() == 0) begin
      protocol_error("W beat with no accepted stream beat behind it");
    end else begin
      compare("wdata", wdata, data_q.pop_front());
      exp_last = ((w_idx % `MAX_BURST_BEATS) == `MAX_BURST_BEATS - 1) ||
                 (w_idx == cur_beats - 1);
      compare("wlast", wlast, exp_last);
      exp_strb = '1;
      // Final beat keeps the low size mod 4 bytes
      if (w_idx == cur_beats - 1 && (cur_size % BEAT_BYTES) != 0) begin
        exp_strb = axi_pkg::axi_strb_t'((1 << (cur_size % BEAT_BYTES)) - 1);
      end
      compare("wstrb", wstrb, exp_strb);
    end
    w_idx++;
    if (wlast) begin
      w_open = 1'b0;
    end
  endtask

  task automatic check_aw();
    aw_total++;
    if (exp_addr_q.size() == 0) begin
      protocol_error("AW request with no burst left in the command");
    end else begin
      compare("awaddr", awaddr, exp_addr_q.pop_front());
      compare("awlen", awlen, exp_len_q.pop_front());
    end
    if (aw_total > w_bursts_seen) begin
      protocol_error("AW request before its first data beat appeared on W");
    end
  endtask

  task automatic count_response();
    b_total++;
    if (!cmd_active) begin
      protocol_error("B response outside a command");
    end else begin
      b_in_cmd++;
      if (b_in_cmd == cur_bursts) begin
        final_b    = 1'b1;
        cmd_active = 1'b0;
      end
    end
  endtask

  task automatic end_checks();
    if (cmd_active) protocol_error("last command never completed");
    if (exp_addr_q.size() != 0) protocol_error("AW requests missing at the end");
    if (data_q.size() != 0) protocol_error("stream beats never appeared on W");
    compare("ctrl_done pulse count", done_count, cmd_count);
  endtask

  ////////////////////////////////////////////////////////////
  // Port monitor
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    if (areset) begin
      done_due = 1'b0;
    end else begin
      final_b = 1'b0;
      if (ctrl_start) begin
        load_command(ctrl_addr_offset, int'(ctrl_xfer_size));
      end
      // FIFO holds exactly the beats accepted and not yet on W
      compare("s_axis_tready", s_axis_tready, data_q.size() < `WR_FIFO_DEPTH);
      if (s_axis_tvalid && s_axis_tready) begin
        data_q.push_back(s_axis_tdata);
      end
      // A burst appears on W with its first valid beat
      if (wvalid && !w_open) begin
        w_open = 1'b1;
        w_bursts_seen++;
      end
      if (wvalid && wready) check_w_beat();
      if (awvalid && awready) check_aw();
      if (bvalid && bready) count_response();
      if (aw_total - b_total > `MAX_OUTSTANDING) begin
        protocol_error("more bursts outstanding than the limit");
      end
      if (bready !== 1'b1) protocol_error("bready dropped");
      // Done one cycle after the final response
      if (ctrl_done || done_due) compare("ctrl_done", ctrl_done, done_due);
      if (ctrl_done) done_count++;
      done_due = final_b;
      if (test_end) end_checks();
    end
  end

endmodule
